/* include/icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Fetch address split into block tag and byte offset
`define ICACHE_ADDR_BITS 16
`define ICACHE_OFFSET_BITS 3
`define ICACHE_TAG_BITS (`ICACHE_ADDR_BITS - `ICACHE_OFFSET_BITS)

// One memory block holds 8 bytes of instructions
`define ICACHE_BLOCK_BITS 64

// Ordinary lines plus lines for streamed blocks, 16 in total
`define ICACHE_LINES 12
`define ICACHE_STREAM_LINES 4

// Memory tags, tag 0 means no tag
`define ICACHE_MEM_TAG_BITS 4
`define ICACHE_NUM_MEM_TAGS 15

// Lookahead step, one block
`define ICACHE_PREFETCH_STRIDE 8

`endif

/* src/icache_pkg.sv */
`include "icache_params.svh"

package icache_pkg;

    // Block tag, address without the offset
    typedef logic [`ICACHE_TAG_BITS-1:0] i_tag_t;

    // Fetch or block address
    typedef logic [`ICACHE_ADDR_BITS-1:0] i_addr_t;

    // Tag handed out by memory for one request
    typedef logic [`ICACHE_MEM_TAG_BITS-1:0] mem_tag_t;

    typedef logic [`ICACHE_BLOCK_BITS-1:0] mem_block_t;

    // One line of the fully associative store
    typedef struct packed {
        logic       valid;
        i_tag_t     tag;
        mem_block_t data;
    } cache_line_t;

    // Outstanding request, memory tag back to block tag
    typedef struct packed {
        logic     valid;
        mem_tag_t mem_tag;
        i_tag_t   tag;
    } mshr_entry_t;

endpackage

/* src/victim_lfsr.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module victim_lfsr (
    input  logic clock,
    input  logic reset,
    output logic [$clog2(`ICACHE_LINES + `ICACHE_STREAM_LINES)-1:0] o_index
);

    localparam int INDEX_BITS = $clog2(`ICACHE_LINES + `ICACHE_STREAM_LINES);
    localparam logic [7:0] SEED = 8'hA5;

    logic [7:0] lfsr;
    logic       feedback;

    // Taps for x^8 + x^6 + x^5 + x^4 + 1, maximal length
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= SEED;
        end else begin
            lfsr <= {lfsr[6:0], feedback};
        end
    end

    // Line count is a power of two so any index is legal
    assign o_index = lfsr[INDEX_BITS-1:0];

endmodule

/* src/icache.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [1:0]                    i_read_valid,
    input  icache_pkg::i_tag_t [1:0]      i_read_tag,
    input  logic                          i_snoop_valid,
    input  icache_pkg::i_tag_t            i_snoop_tag,
    input  logic                          i_fill_valid,
    input  icache_pkg::i_tag_t            i_fill_tag,
    input  icache_pkg::mem_block_t        i_fill_data,
    output logic [1:0]                    o_read_hit,
    output icache_pkg::mem_block_t [1:0]  o_read_data,
    output logic                          o_snoop_found,
    output logic                          o_full
);

    localparam int DEPTH = `ICACHE_LINES + `ICACHE_STREAM_LINES;
    localparam int INDEX_BITS = $clog2(DEPTH);

    icache_pkg::cache_line_t lines [DEPTH];

    logic [DEPTH-1:0]      valid_bits;
    logic [DEPTH-1:0]      snoop_match;
    logic                  free_found;
    logic [INDEX_BITS-1:0] free_index;
    logic [INDEX_BITS-1:0] victim_index;
    logic [INDEX_BITS-1:0] fill_index;

    victim_lfsr u_victim_lfsr (
        .clock   (clock),
        .reset   (reset),
        .o_index (victim_index)
    );

    // Valid vector and snoop compare across all lines
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            valid_bits[i]  = lines[i].valid;
            snoop_match[i] = lines[i].valid && (lines[i].tag == i_snoop_tag);
        end
    end

    assign o_snoop_found = i_snoop_valid && (|snoop_match);
    assign o_full        = &valid_bits;

    // Lowest numbered invalid line wins
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid_bits[i]) begin
                free_found = 1'b1;
                free_index = INDEX_BITS'(i);
            end
        end
    end

    // Random eviction only once every line is taken
    assign fill_index = free_found ? free_index : victim_index;

    // Two read ports, tags are unique so at most one line matches
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            o_read_hit[p]  = 1'b0;
            o_read_data[p] = '0;
            for (int i = 0; i < DEPTH; i++) begin
                if (i_read_valid[p] && lines[i].valid && (lines[i].tag == i_read_tag[p])) begin
                    o_read_hit[p]  = 1'b1;
                    o_read_data[p] = lines[i].data;
                end
            end
        end
    end

    // Refill from the MSHR head, visible to fetch the next cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (i_fill_valid) begin
            lines[fill_index] <= '{valid: 1'b1, tag: i_fill_tag, data: i_fill_data};
        end
    end

endmodule

/* src/i_mshr.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module i_mshr (
    input  logic                  clock,
    input  logic                  reset,
    input  icache_pkg::i_tag_t    i_snoop_tag,
    output logic                  o_snoop_found,
    input  logic                  i_push_valid,
    input  icache_pkg::mem_tag_t  i_push_mem_tag,
    input  icache_pkg::i_tag_t    i_push_tag,
    input  icache_pkg::mem_tag_t  i_return_tag,
    output logic                  o_fill_valid,
    output icache_pkg::i_tag_t    o_fill_tag
);

    localparam int DEPTH = `ICACHE_NUM_MEM_TAGS + 1;
    localparam int PTR_BITS = $clog2(DEPTH);

    icache_pkg::mshr_entry_t entries [DEPTH];

    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [DEPTH-1:0]    snoop_match;
    logic                pop;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Any outstanding request for the same block
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            snoop_match[i] = entries[i].valid && (entries[i].tag == i_snoop_tag);
        end
    end

    assign o_snoop_found = |snoop_match;

    // Returns come back in order, so only the head can match
    assign pop = (i_return_tag != '0) && entries[head].valid &&
                 (entries[head].mem_tag == i_return_tag);

    assign o_fill_valid = pop;
    assign o_fill_tag   = entries[head].tag;

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head                <= next_ptr(head);
            end
            // At most 15 tags in flight, the tail never reaches a live head
            if (i_push_valid) begin
                entries[tail] <= '{valid: 1'b1, mem_tag: i_push_mem_tag, tag: i_push_tag};
                tail          <= next_ptr(tail);
            end
        end
    end

endmodule

/* src/i_prefetcher.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module i_prefetcher (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 i_miss_valid,
    input  icache_pkg::i_addr_t  i_miss_addr,
    input  logic                 i_cache_full,
    input  logic                 i_req_accepted,
    output logic                 o_snoop_valid,
    output icache_pkg::i_addr_t  o_snoop_addr
);

    localparam icache_pkg::i_addr_t STRIDE = icache_pkg::i_addr_t'(`ICACHE_PREFETCH_STRIDE);

    logic                last_valid;
    icache_pkg::i_addr_t last_miss;
    icache_pkg::i_addr_t pointer;
    icache_pkg::i_addr_t miss_block;
    icache_pkg::i_addr_t ahead_addr;
    logic                new_miss;

    assign miss_block = {i_miss_addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                         {`ICACHE_OFFSET_BITS{1'b0}}};
    assign ahead_addr = pointer + STRIDE;

    // Demand miss not yet requested takes priority over lookahead
    assign new_miss = i_miss_valid && (!last_valid || (miss_block != last_miss));

    always_comb begin
        o_snoop_valid = 1'b0;
        o_snoop_addr  = '0;
        if (new_miss) begin
            o_snoop_valid = 1'b1;
            o_snoop_addr  = miss_block;
        end else if (!i_cache_full && last_valid) begin
            o_snoop_valid = 1'b1;
            o_snoop_addr  = ahead_addr;
        end
    end

    // State moves only on an accepted request
    always_ff @(posedge clock) begin
        if (reset) begin
            last_valid <= 1'b0;
        end else if (i_req_accepted) begin
            if (new_miss) begin
                last_valid <= 1'b1;
                last_miss  <= miss_block;
                pointer    <= miss_block;
            end else if (o_snoop_valid) begin
                pointer <= ahead_addr;
            end
        end
    end

endmodule

/* src/icache_subsystem.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_subsystem (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [1:0]                    i_fetch_valid,
    input  icache_pkg::i_addr_t [1:0]     i_fetch_addr,
    output logic [1:0]                    o_fetch_hit,
    output icache_pkg::mem_block_t [1:0]  o_fetch_data,
    output logic                          o_mem_req_valid,
    output icache_pkg::i_addr_t           o_mem_req_addr,
    input  logic                          i_mem_req_accepted,
    input  icache_pkg::mem_tag_t          i_current_req_tag,
    input  icache_pkg::mem_block_t        i_mem_data,
    input  icache_pkg::mem_tag_t          i_mem_data_tag
);

    icache_pkg::i_tag_t [1:0] fetch_tag;
    logic                     miss_valid;
    icache_pkg::i_addr_t      miss_addr;
    logic                     snoop_valid;
    icache_pkg::i_addr_t      snoop_addr;
    icache_pkg::i_tag_t       snoop_tag;
    logic                     snoop_in_cache;
    logic                     snoop_in_mshr;
    logic                     full;
    logic                     fill_valid;
    icache_pkg::i_tag_t       fill_tag;
    logic                     push_valid;

    assign fetch_tag[0] = i_fetch_addr[0][`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS];
    assign fetch_tag[1] = i_fetch_addr[1][`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS];
    assign snoop_tag    = snoop_addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS];

    icache u_icache (
        .clock (clock), .reset (reset),
        .i_read_valid (i_fetch_valid), .i_read_tag (fetch_tag),
        .i_snoop_valid (snoop_valid), .i_snoop_tag (snoop_tag),
        .i_fill_valid (fill_valid), .i_fill_tag (fill_tag), .i_fill_data (i_mem_data),
        .o_read_hit (o_fetch_hit), .o_read_data (o_fetch_data),
        .o_snoop_found (snoop_in_cache), .o_full (full)
    );

    i_mshr u_mshr (
        .clock (clock), .reset (reset),
        .i_snoop_tag (snoop_tag), .o_snoop_found (snoop_in_mshr),
        .i_push_valid (push_valid), .i_push_mem_tag (i_current_req_tag),
        .i_push_tag (snoop_tag), .i_return_tag (i_mem_data_tag),
        .o_fill_valid (fill_valid), .o_fill_tag (fill_tag)
    );

    i_prefetcher u_prefetcher (
        .clock (clock), .reset (reset),
        .i_miss_valid (miss_valid), .i_miss_addr (miss_addr),
        .i_cache_full (full), .i_req_accepted (i_mem_req_accepted),
        .o_snoop_valid (snoop_valid), .o_snoop_addr (snoop_addr)
    );

    // Port 0 holds the older fetch
    assign miss_valid = (i_fetch_valid[0] && !o_fetch_hit[0]) ||
                        (i_fetch_valid[1] && !o_fetch_hit[1]);
    assign miss_addr  = (i_fetch_valid[0] && !o_fetch_hit[0]) ? i_fetch_addr[0] : i_fetch_addr[1];

    // Only blocks that are neither cached nor in flight go out
    assign o_mem_req_valid = snoop_valid && !snoop_in_cache && !snoop_in_mshr;
    assign o_mem_req_addr  = {snoop_tag, {`ICACHE_OFFSET_BITS{1'b0}}};

    // New MSHR entry when memory takes the request with a real tag
    assign push_valid = i_mem_req_accepted && (i_current_req_tag != '0);

endmodule

/* dv/icache_subsystem_tb.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_subsystem_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS = 6;
    localparam int TEST_CYCLES = 400;
    localparam int WATCHDOG_NS =
        (NUM_TESTS * (TEST_CYCLES + RESET_CYCLES) + RESET_CYCLES) * CLK_PERIOD;
    localparam int WAIT_LIMIT = 50;
    localparam int CACHE_LINES = `ICACHE_LINES + `ICACHE_STREAM_LINES;
    localparam icache_pkg::mem_block_t DATA_KEY = 64'h5A5A_C3C3_0F0F_9669;

    logic                             clock;
    logic                             reset = 1'b1;
    logic [1:0]                       fetch_valid = 2'b00;
    icache_pkg::i_addr_t [1:0]        fetch_addr = '0;
    logic [1:0]                       o_fetch_hit;
    icache_pkg::mem_block_t [1:0]     o_fetch_data;
    logic                             o_mem_req_valid;
    icache_pkg::i_addr_t              o_mem_req_addr;
    logic                             mem_req_accepted = 1'b0;
    icache_pkg::mem_tag_t             current_req_tag = '0;
    icache_pkg::mem_block_t           mem_data = '0;
    icache_pkg::mem_tag_t             mem_data_tag = '0;

    // Memory model state and the log of accepted requests
    icache_pkg::i_addr_t  pending_addr[$];
    icache_pkg::mem_tag_t pending_tag[$];
    int                   pending_due[$];
    icache_pkg::i_addr_t  log_addr[$];
    int                   log_fills[$];
    icache_pkg::mem_tag_t next_tag = 4'd1;
    int                   returns_done = 0;
    int                   last_due = 0;
    int                   mem_latency = 4;
    int                   due = 0;
    int                   cycle = 0;
    bit                   random_latency = 1'b0;
    logic [31:0]          rng_state = 32'd54291;
    int                   error_count = 0;
    int                   tests_run = 0;

    icache_subsystem UUT (
        .clock (clock), .reset (reset),
        .i_fetch_valid (fetch_valid), .i_fetch_addr (fetch_addr),
        .o_fetch_hit (o_fetch_hit), .o_fetch_data (o_fetch_data),
        .o_mem_req_valid (o_mem_req_valid), .o_mem_req_addr (o_mem_req_addr),
        .i_mem_req_accepted (mem_req_accepted), .i_current_req_tag (current_req_tag),
        .i_mem_data (mem_data), .i_mem_data_tag (mem_data_tag)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic icache_pkg::i_addr_t block_of(input icache_pkg::i_addr_t addr);
        return {addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
    endfunction

    // Memory holds the block address four times XOR a fixed key
    function automatic icache_pkg::mem_block_t block_data(input icache_pkg::i_addr_t addr);
        return {4{addr}} ^ DATA_KEY;
    endfunction

    task automatic report_mismatch(input string test_name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        error_count++;
        $display("[FAIL] %s: expected %h, actual %h", test_name, expected, actual);
    endtask

    task automatic report_problem(input string test_name, input string what);
        error_count++;
        $display("Error in %s: %s", test_name, what);
    endtask

    // Memory model accepts every request and answers in order
    always @(negedge clock) begin
        #1;
        if (reset) begin
            pending_addr.delete();
            pending_tag.delete();
            pending_due.delete();
            mem_req_accepted = 1'b0;
            current_req_tag = '0;
            mem_data_tag = '0;
            next_tag = 4'd1;
            returns_done = 0;
            last_due = 0;
        end else begin
            if (o_mem_req_valid) begin
                mem_req_accepted = 1'b1;
                current_req_tag = next_tag;
                log_addr.push_back(o_mem_req_addr);
                log_fills.push_back(returns_done);
                mem_latency = 4;
                if (random_latency) begin
                    rng_state = next_random(rng_state);
                    mem_latency = 2 + int'(rng_state % 32'd6);
                end
                // Keep returns in acceptance order and at most one per cycle
                due = cycle + mem_latency;
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pending_addr.push_back(o_mem_req_addr);
                pending_tag.push_back(next_tag);
                pending_due.push_back(due);
                if (next_tag == icache_pkg::mem_tag_t'(`ICACHE_NUM_MEM_TAGS)) begin
                    next_tag = 4'd1;
                end else begin
                    next_tag = next_tag + 4'd1;
                end
            end else begin
                mem_req_accepted = 1'b0;
                current_req_tag = '0;
            end
            if (pending_due.size() > 0 && pending_due[0] <= cycle) begin
                mem_data = block_data(pending_addr[0]);
                mem_data_tag = pending_tag[0];
                pending_addr.pop_front();
                pending_tag.pop_front();
                pending_due.pop_front();
                returns_done++;
            end else begin
                mem_data_tag = '0;
            end
        end
    end

    task automatic apply_reset();
        @(negedge clock);
        reset = 1'b1;
        fetch_valid = 2'b00;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        log_addr.delete();
        log_fills.delete();
    endtask

    // Drives one fetch cycle and samples outputs late in the low phase
    task automatic fetch_cycle(input logic [1:0] valid, input icache_pkg::i_addr_t addr0,
                               input icache_pkg::i_addr_t addr1);
        @(negedge clock);
        fetch_valid = valid;
        fetch_addr[0] = addr0;
        fetch_addr[1] = addr1;
        #4;
    endtask

    task automatic fetch_until_hit(input int port, input logic [1:0] valid,
                                   input icache_pkg::i_addr_t addr0,
                                   input icache_pkg::i_addr_t addr1);
        int waited;
        waited = 0;
        fetch_cycle(valid, addr0, addr1);
        while (!o_fetch_hit[port] && waited < WAIT_LIMIT) begin
            fetch_cycle(valid, addr0, addr1);
            waited++;
        end
    endtask

    task automatic idle_after_reset();
        icache_pkg::i_addr_t warm;
        tests_run++;
        warm = 16'h0A10;
        // Warm the cache and start a stream before the reset under test
        apply_reset();
        fetch_until_hit(0, 2'b01, warm, '0);
        if (!o_fetch_hit[0]) begin
            report_problem("reset_idle", "port 0 never hit before the second reset");
        end
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            fetch_cycle(2'b00, '0, '0);
            if (o_mem_req_valid !== 1'b0) begin
                report_mismatch("reset_idle", 64'(0), 64'(o_mem_req_valid));
            end
        end
        // Fewer cycles than the memory latency so nothing is refilled yet
        for (int i = 0; i < 4; i++) begin
            rng_state = next_random(rng_state);
            fetch_cycle(2'b11, warm, rng_state[15:0]);
            if (o_fetch_hit !== 2'b00) begin
                report_mismatch("reset_idle", 64'(0), 64'(o_fetch_hit));
            end
        end
    endtask

    task automatic demand_miss_refill();
        icache_pkg::i_addr_t addr;
        icache_pkg::i_addr_t block;
        tests_run++;
        addr = 16'h1234;
        block = block_of(addr);
        apply_reset();
        fetch_until_hit(0, 2'b01, addr, '0);
        if (log_addr.size() == 0) begin
            report_problem("demand_miss", "no request was accepted for the miss");
        end else if (log_addr[0] != block) begin
            report_mismatch("demand_miss", 64'(block), 64'(log_addr[0]));
        end
        if (!o_fetch_hit[0]) begin
            report_problem("demand_miss", "port 0 never hit after the refill");
        end
        fetch_cycle(2'b11, addr, block | 16'h0001);
        if (o_fetch_hit !== 2'b11) begin
            report_mismatch("demand_miss", 64'(2'b11), 64'(o_fetch_hit));
        end
        for (int p = 0; p < 2; p++) begin
            if (o_fetch_data[p] != block_data(block)) begin
                report_mismatch("demand_miss", block_data(block), o_fetch_data[p]);
            end
        end
    endtask

    task automatic sequential_stream();
        icache_pkg::i_addr_t base;
        icache_pkg::i_addr_t expected;
        tests_run++;
        base = 16'h2000;
        apply_reset();
        fetch_until_hit(0, 2'b01, base, '0);
        repeat (60) fetch_cycle(2'b01, base, '0);
        if (log_addr.size() < CACHE_LINES) begin
            report_problem("stream_ahead", "fewer blocks requested than the cache holds");
        end
        for (int i = 0; i < log_addr.size(); i++) begin
            expected = base + icache_pkg::i_addr_t'(i * `ICACHE_PREFETCH_STRIDE);
            if (log_addr[i] != expected) begin
                report_mismatch("stream_ahead", 64'(expected), 64'(log_addr[i]));
            end
            if (log_fills[i] >= CACHE_LINES) begin
                report_problem("stream_ahead", "a request was accepted after the cache was full");
            end
        end
    endtask

    task automatic duplicate_suppression();
        tests_run++;
        apply_reset();
        // Port 0 flips between two blocks while both are still in flight
        for (int i = 0; i < 30; i++) begin
            fetch_cycle(2'b11, (i % 2 == 0) ? 16'h4008 : 16'h4404, 16'h4013);
        end
        repeat (30) fetch_cycle(2'b00, '0, '0);
        for (int i = 0; i < log_addr.size(); i++) begin
            for (int j = 0; j < i; j++) begin
                if (log_fills[i] <= CACHE_LINES && log_addr[i] == log_addr[j]) begin
                    report_problem("no_duplicates", "a block address was requested twice");
                end
            end
        end
    endtask

    task automatic port_priority();
        icache_pkg::i_addr_t p_addr;
        icache_pkg::i_addr_t q_addr;
        tests_run++;
        p_addr = 16'h6000;
        q_addr = 16'h7104;
        apply_reset();
        fetch_cycle(2'b11, p_addr, q_addr);
        if (log_addr.size() == 0) begin
            report_problem("port_priority", "no request was accepted for the two misses");
        end else if (log_addr[0] != block_of(p_addr)) begin
            report_mismatch("port_priority", 64'(block_of(p_addr)), 64'(log_addr[0]));
        end
        fetch_until_hit(0, 2'b11, p_addr, q_addr);
        if (!o_fetch_hit[0]) begin
            report_problem("port_priority", "port 0 never hit");
        end else begin
            if (o_fetch_hit[1] !== 1'b0) begin
                report_mismatch("port_priority", 64'(0), 64'(o_fetch_hit[1]));
            end
            if (!o_mem_req_valid || o_mem_req_addr != block_of(q_addr)) begin
                report_mismatch("port_priority", 64'({1'b1, block_of(q_addr)}),
                                64'({o_mem_req_valid, o_mem_req_addr}));
            end
        end
        fetch_until_hit(1, 2'b11, p_addr, q_addr);
        if (o_fetch_hit !== 2'b11) begin
            report_mismatch("port_priority", 64'(2'b11), 64'(o_fetch_hit));
        end
        if (o_fetch_data[1] != block_data(block_of(q_addr))) begin
            report_mismatch("port_priority", block_data(block_of(q_addr)), o_fetch_data[1]);
        end
    endtask

    task automatic random_traffic();
        tests_run++;
        apply_reset();
        random_latency = 1'b1;
        // 64 distinct blocks is four times the cache capacity
        for (int i = 0; i < 200; i++) begin
            rng_state = next_random(rng_state);
            fetch_cycle(rng_state[31:30], {7'h40, rng_state[8:0]}, {7'h40, rng_state[24:16]});
            for (int p = 0; p < 2; p++) begin
                if (o_fetch_hit[p] && o_fetch_data[p] != block_data(block_of(fetch_addr[p]))) begin
                    report_mismatch("random_traffic", block_data(block_of(fetch_addr[p])),
                                    o_fetch_data[p]);
                end
            end
        end
        random_latency = 1'b0;
        for (int i = 0; i < log_addr.size(); i++) begin
            if (log_addr[i][`ICACHE_OFFSET_BITS-1:0] != '0) begin
                report_mismatch("random_traffic", 64'(block_of(log_addr[i])), 64'(log_addr[i]));
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        idle_after_reset();
        demand_miss_refill();
        sequential_stream();
        duplicate_suppression();
        port_priority();
        random_traffic();
        $display("Summary: %0d tests run, %0d errors", tests_run, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
src/icache_pkg.sv
src/victim_lfsr.sv
src/icache.sv
src/i_mshr.sv
src/i_prefetcher.sv
src/icache_subsystem.sv
dv/icache_subsystem_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f sources.f --top-module icache_subsystem_tb \
		-Mdir obj_dir -o icache_sim

run: compile
	./obj_dir/icache_sim | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
